// ==== verilog/renkon_defs.svh ====
`ifndef RENKON_DEFS_SVH
`define RENKON_DEFS_SVH

// signed fixed point word, the lower half of it is fraction
`define DWIDTH 16

// depth of one line buffer in pixels
`define IMG_MAX_WIDTH 32

// width of the frame size and position fields
`define IMG_SIZE_BITS 6

// sampling edge of a completing pixel to out_valid, window register plus four tree stages
`define CONV_LATENCY 5

`endif

// ==== verilog/renkon_pkg.sv ====
`include "renkon_defs.svh"

package renkon_pkg;

  typedef logic signed [`DWIDTH-1:0] pixel_t;

  // p0 is the top-left pixel of the window and p8 the newest one
  typedef struct packed {
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    pixel_t p4;
    pixel_t p5;
    pixel_t p6;
    pixel_t p7;
    pixel_t p8;
  } window_t;

  typedef struct packed {
    pixel_t w0;
    pixel_t w1;
    pixel_t w2;
    pixel_t w3;
    pixel_t w4;
    pixel_t w5;
    pixel_t w6;
    pixel_t w7;
    pixel_t w8;
  } kernel_t;

  typedef struct packed {
    logic [`IMG_SIZE_BITS-1:0] width;
    logic [`IMG_SIZE_BITS-1:0] height;
  } frame_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } conv_state_t;

endpackage

// ==== verilog/conv_ctrl.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module conv_ctrl (
  input  logic clk,
  input  logic xrst,
  input  logic start,
  input  logic last_pixel,
  input  logic pixel_valid,
  input  logic tree_valid,
  output logic busy,
  output logic frame_start,
  output logic pixel_accept,
  output logic done
);

  localparam int TIMER_BITS = $clog2(`CONV_LATENCY + 1);

  renkon_pkg::conv_state_t state;
  renkon_pkg::conv_state_t state_next;
  logic [TIMER_BITS-1:0]   drain_cnt;
  logic                    drain_end;

  assign frame_start  = start && (state == renkon_pkg::IDLE);
  assign pixel_accept = pixel_valid && (state == renkon_pkg::RUN);
  assign busy         = (state != renkon_pkg::IDLE);

  // the last window leaves the tree while the timer reads one
  // a frame too small to hold a window lets the timer run out instead
  assign drain_end = (drain_cnt == TIMER_BITS'(1) && tree_valid) || (drain_cnt == '0);

  always_comb begin
    state_next = state;
    case (state)
      renkon_pkg::IDLE: begin
        if (start) begin
          state_next = renkon_pkg::RUN;
        end
      end
      renkon_pkg::RUN: begin
        if (last_pixel) begin
          state_next = renkon_pkg::DRAIN;
        end
      end
      renkon_pkg::DRAIN: begin
        if (drain_end) begin
          state_next = renkon_pkg::IDLE;
        end
      end
      default: begin
        state_next = renkon_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      state     <= renkon_pkg::IDLE;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == renkon_pkg::DRAIN) && drain_end;
      if (state == renkon_pkg::RUN && last_pixel) begin
        drain_cnt <= TIMER_BITS'(`CONV_LATENCY);
      end else if (state == renkon_pkg::DRAIN && drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/pixel_counter.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module pixel_counter (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   frame_start,
  input  logic                   pixel_accept,
  input  renkon_pkg::frame_cfg_t cfg,
  output logic                   window_valid,
  output logic                   last_pixel
);

  renkon_pkg::frame_cfg_t    cfg_q;
  logic [`IMG_SIZE_BITS-1:0] col;
  logic [`IMG_SIZE_BITS-1:0] row;
  logic [`IMG_SIZE_BITS-1:0] last_col;
  logic [`IMG_SIZE_BITS-1:0] last_row;
  logic                      col_end;

  assign last_col = cfg_q.width - 1'b1;
  assign last_row = cfg_q.height - 1'b1;
  assign col_end  = (col == last_col);

  // high in the cycle that the final pixel of the frame is taken
  assign last_pixel = pixel_accept && col_end && (row == last_row);

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      cfg_q        <= '0;
      col          <= '0;
      row          <= '0;
      window_valid <= 1'b0;
    end else begin
      // a window is complete once two rows and two columns lie behind the pixel
      window_valid <= pixel_accept && (col >= 'd2) && (row >= 'd2);
      if (frame_start) begin
        cfg_q <= cfg;
        col   <= '0;
        row   <= '0;
      end else if (pixel_accept) begin
        if (col_end) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/line_window.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module line_window (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      pixel_accept,
  input  renkon_pkg::pixel_t        pixel,
  input  logic [`IMG_SIZE_BITS-1:0] width,
  output renkon_pkg::window_t       window
);

  localparam int ADDR_BITS = $clog2(`IMG_MAX_WIDTH);

  // line_up1 holds the row above the incoming pixel, line_up2 the one above that
  renkon_pkg::pixel_t        line_up1 [`IMG_MAX_WIDTH];
  renkon_pkg::pixel_t        line_up2 [`IMG_MAX_WIDTH];
  logic [`IMG_SIZE_BITS-1:0] col;
  logic [`IMG_SIZE_BITS-1:0] last_col;
  logic [ADDR_BITS-1:0]      addr;
  renkon_pkg::pixel_t        above1;
  renkon_pkg::pixel_t        above2;
  renkon_pkg::pixel_t [0:2]  row_top;
  renkon_pkg::pixel_t [0:2]  row_mid;
  renkon_pkg::pixel_t [0:2]  row_bot;

  assign last_col = width - 1'b1;
  assign addr     = col[ADDR_BITS-1:0];
  assign above1   = line_up1[addr];
  assign above2   = line_up2[addr];

  // column pointer ends at zero after a whole frame, so the next frame lines up
  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      col <= '0;
    end else if (pixel_accept) begin
      if (col == last_col) begin
        col <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // each accepted pixel pushes the column down by one row
  always_ff @(posedge clk) begin
    if (pixel_accept) begin
      line_up1[addr] <= pixel;
      line_up2[addr] <= above1;
    end
  end

  // the newest column enters at index 2 of each row
  always_ff @(posedge clk) begin
    if (pixel_accept) begin
      row_top <= {row_top[1], row_top[2], above2};
      row_mid <= {row_mid[1], row_mid[2], above1};
      row_bot <= {row_bot[1], row_bot[2], pixel};
    end
  end

  // index 0 of a packed [0:2] array is its most significant element, which maps to p0
  assign window = {row_top, row_mid, row_bot};

endmodule

// ==== verilog/conv_tree9.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module conv_tree9 (
  input  logic                clk,
  input  logic                xrst,
  input  renkon_pkg::window_t window,
  input  renkon_pkg::kernel_t kernel,
  input  logic                in_valid,
  output renkon_pkg::pixel_t  out_pixel,
  output logic                out_valid
);

  localparam int PROD_BITS = 2 * `DWIDTH;
  localparam int FRAC_BITS = `DWIDTH / 2;
  localparam int KEEP_MSB  = PROD_BITS - FRAC_BITS - 2;

  renkon_pkg::pixel_t [0:8]    pix_q;
  renkon_pkg::pixel_t [0:8]    wgt_q;
  logic signed [PROD_BITS-1:0] prod_d [9];
  logic signed [PROD_BITS-1:0] prod_q [9];
  renkon_pkg::pixel_t          rnd_q [9];
  renkon_pkg::pixel_t          sum_l0 [4];
  renkon_pkg::pixel_t          sum_l1 [2];
  renkon_pkg::pixel_t          sum_d;
  // bit 0 marks operands, 1 products, 2 rounded products, 3 the sum
  logic [3:0]                  valid_pipe;

  // bit KEEP_MSB becomes the sign, everything above it is dropped
  // negative products with an empty fraction are pulled down by one
  function automatic renkon_pkg::pixel_t round_prod(input logic signed [PROD_BITS-1:0] prod);
    logic [KEEP_MSB-FRAC_BITS:0] kept;
    kept = prod[KEEP_MSB:FRAC_BITS];
    if (prod[KEEP_MSB] && (prod[FRAC_BITS-1:0] == '0)) begin
      kept = kept - 1'b1;
    end
    return {prod[KEEP_MSB], kept};
  endfunction

  for (genvar i = 0; i < 9; i++) begin : g_mult
    assign prod_d[i] = $signed(pix_q[i]) * $signed(wgt_q[i]);
  end

  for (genvar i = 0; i < 4; i++) begin : g_pair
    assign sum_l0[i] = rnd_q[2*i] + rnd_q[2*i+1];
  end

  assign sum_l1[0] = sum_l0[0] + sum_l0[1];
  assign sum_l1[1] = sum_l0[2] + sum_l0[3];
  // tap 8 has no partner and joins at the last level, all sums wrap
  assign sum_d     = sum_l1[0] + sum_l1[1] + rnd_q[8];

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[2:0], in_valid};
    end
  end

  // stages load only behind a valid window, so unfilled line buffer words never enter
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pix_q <= window;
      wgt_q <= kernel;
    end
    if (valid_pipe[0]) begin
      for (int i = 0; i < 9; i++) begin
        prod_q[i] <= prod_d[i];
      end
    end
    if (valid_pipe[1]) begin
      for (int i = 0; i < 9; i++) begin
        rnd_q[i] <= round_prod(prod_q[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge xrst) begin
    if (!xrst) begin
      out_pixel <= '0;
    end else if (valid_pipe[2]) begin
      out_pixel <= sum_d;
    end
  end

  assign out_valid = valid_pipe[3];

endmodule

// ==== verilog/renkon_conv.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   start,
  input  renkon_pkg::frame_cfg_t cfg,
  input  renkon_pkg::kernel_t    kernel,
  input  logic                   pixel_valid,
  input  renkon_pkg::pixel_t     pixel,
  output logic                   busy,
  output logic                   out_valid,
  output renkon_pkg::pixel_t     out_pixel,
  output logic                   done
);

  logic                frame_start;
  logic                pixel_accept;
  logic                last_pixel;
  logic                window_valid;
  renkon_pkg::window_t window;

  conv_ctrl u_ctrl (
    .clk          (clk),
    .xrst         (xrst),
    .start        (start),
    .last_pixel   (last_pixel),
    .pixel_valid  (pixel_valid),
    .tree_valid   (out_valid),
    .busy         (busy),
    .frame_start  (frame_start),
    .pixel_accept (pixel_accept),
    .done         (done)
  );

  pixel_counter u_counter (
    .clk          (clk),
    .xrst         (xrst),
    .frame_start  (frame_start),
    .pixel_accept (pixel_accept),
    .cfg          (cfg),
    .window_valid (window_valid),
    .last_pixel   (last_pixel)
  );

  // the pointer follows the live width, cfg stays stable for the whole frame
  line_window u_window (
    .clk          (clk),
    .xrst         (xrst),
    .pixel_accept (pixel_accept),
    .pixel        (pixel),
    .width        (cfg.width),
    .window       (window)
  );

  conv_tree9 u_tree (
    .clk       (clk),
    .xrst      (xrst),
    .window    (window),
    .kernel    (kernel),
    .in_valid  (window_valid),
    .out_pixel (out_pixel),
    .out_valid (out_valid)
  );

endmodule

// ==== verif/renkon_conv_assertions.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv_assertions (
  input logic                    clk,
  input logic                    xrst,
  input logic                    busy,
  input logic                    done,
  input logic                    out_valid,
  input renkon_pkg::conv_state_t state
);

  done_one_cycle: assert property (@(posedge clk) disable iff (!xrst)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  out_valid_while_busy: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> busy)
    else $error("out_valid seen while busy was low");

  busy_falls_with_done: assert property (@(posedge clk) disable iff (!xrst)
    $fell(busy) |-> done)
    else $error("busy fell without a done pulse");

  // each result stems from a pixel taken in RUN and never from a strobe in IDLE
  no_output_in_idle: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> ($past(state, `CONV_LATENCY) == renkon_pkg::RUN))
    else $error("out_valid seen for a pixel that was not taken in RUN");

endmodule

bind renkon_conv renkon_conv_assertions u_assertions (
  .clk       (clk),
  .xrst      (xrst),
  .busy      (busy),
  .done      (done),
  .out_valid (out_valid),
  .state     (u_ctrl.state)
);

// ==== verif/renkon_conv_tb.sv ====
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv_tb;

  logic                   clk;
  logic                   xrst;
  logic                   start;
  renkon_pkg::frame_cfg_t cfg;
  renkon_pkg::kernel_t    kernel;
  logic                   pixel_valid;
  renkon_pkg::pixel_t     pixel;
  logic                   busy;
  logic                   out_valid;
  renkon_pkg::pixel_t     out_pixel;
  logic                   done;

  logic [15:0] vec [0:127];
  logic [31:0] lfsr;
  // set with a pixel whose window is complete, used for the latency check
  logic        completes;
  int          errors;
  int          checks;
  int          cycle;
  int          out_cnt;
  int          done_cnt;
  int          n_out;
  int          exp_base;
  int          watchdog_limit;
  string       frame_name;
  int          sample_times[$];

  renkon_conv UUT (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .cfg         (cfg),
    .kernel      (kernel),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .busy        (busy),
    .out_valid   (out_valid),
    .out_pixel   (out_pixel),
    .done        (done)
  );

  always #50 clk = ~clk;

  // fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  always @(posedge clk) begin
    if (pixel_valid && completes) begin
      sample_times.push_back(cycle);
    end
    if (out_valid) begin
      if (sample_times.size() == 0) begin
        errors++;
        $display("out_valid arrived with no completing pixel before it");
      end else begin
        check_value($sformatf("%s latency %0d", frame_name, out_cnt),
                    `CONV_LATENCY, cycle - sample_times.pop_front());
      end
      if (out_cnt < n_out) begin
        check_value($sformatf("%s out %0d", frame_name, out_cnt),
                    {16'h0, vec[exp_base + out_cnt]}, {16'h0, out_pixel});
      end
      out_cnt++;
    end
    if (done) begin
      done_cnt++;
      // all results must be out before done
      check_value({frame_name, " outputs at done"}, n_out, out_cnt);
    end
    cycle = cycle + 1;
  end

  task automatic run_frame(input int base, input string name);
    int w;
    int h;
    int npix;
    int gap;
    int k;
    w          = vec[base];
    h          = vec[base + 1];
    npix       = w * h;
    frame_name = name;
    n_out      = (w - 2) * (h - 2);
    exp_base   = base + 11 + npix;
    out_cnt    = 0;
    done_cnt   = 0;
    @(posedge clk);
    cfg    <= '{width: w, height: h};
    kernel <= {vec[base + 2], vec[base + 3], vec[base + 4], vec[base + 5], vec[base + 6],
               vec[base + 7], vec[base + 8], vec[base + 9], vec[base + 10]};
    start  <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    for (int i = 0; i < npix; i++) begin
      gap = 0;
      for (int b = 0; b < 2; b++) begin
        lfsr = lfsr_next(lfsr);
        gap  = (gap << 1) | lfsr[0];
      end
      repeat (gap) begin
        pixel_valid <= 1'b0;
        completes   <= 1'b0;
        start       <= 1'b0;
        @(posedge clk);
      end
      pixel_valid <= 1'b1;
      pixel       <= vec[base + 11 + i];
      completes   <= (i % w >= 2) && (i / w >= 2);
      // a second start in the middle of the frame must be ignored
      start       <= (i == npix / 2);
      @(posedge clk);
    end
    pixel_valid <= 1'b0;
    completes   <= 1'b0;
    start       <= 1'b0;
    k = 0;
    while (done_cnt == 0 && k < 50) begin
      @(posedge clk);
      k++;
    end
    if (done_cnt == 0) begin
      errors++;
      $display("%s never pulsed done after its last pixel", name);
    end
    @(posedge clk);
    check_value({name, " busy after done"}, 0, busy);
    check_value({name, " output count"}, n_out, out_cnt);
    check_value({name, " done count"}, 1, done_cnt);
  endtask

  initial begin
    wait (watchdog_limit > 0);
    repeat (watchdog_limit) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", watchdog_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    xrst        = 1'b0;
    start       = 1'b0;
    cfg         = '0;
    kernel      = '0;
    pixel_valid = 1'b0;
    pixel       = '0;
    completes   = 1'b0;
    lfsr        = 32'h52cd0e13;
    errors      = 0;
    checks      = 0;
    cycle       = 0;
    n_out       = 0;
    exp_base    = 0;
    frame_name  = "idle";
    $readmemh("verif/conv_vectors.txt", vec);
    watchdog_limit = (20 + 6 + 18 + 4) * 8 + 200;
    repeat (10) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    check_value("reset busy", 0, busy);
    check_value("reset done", 0, done);
    check_value("reset out_valid", 0, out_valid);
    check_value("reset out_pixel", 0, {16'h0, out_pixel});
    // strobes in IDLE are dropped
    repeat (4) begin
      pixel_valid <= 1'b1;
      pixel       <= 16'h00ff;
      @(posedge clk);
    end
    pixel_valid <= 1'b0;
    repeat (8) @(posedge clk);
    check_value("idle strobes output count", 0, out_cnt);
    check_value("idle strobes busy", 0, busy);
    run_frame(0, "frame1");
    run_frame(37, "frame2");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verif/conv_vectors.txt ====
// per frame: width height, kernel weights w0..w8, pixels in raster order,
// then expected outputs in raster order, all hex words
// frame 1, 5 x 4
0005 0004
0100 0000 0100 0000 0200 0000 0100 0000 0100
0001 0002 0003 0004 0005
0006 0007 0008 0009 000a
000b 000c 000d 000e 000f
0010 0011 0012 0013 0014
002a 0030 0036 0048 004e 0054
// frame 2, 6 x 3, negative weights take the rounding correction
0006 0003
ff00 0000 0100 fe00 0000 0200 ff00 0000 0100
0003 0001 0004 0001 0005 0009
0002 0006 0005 0003 0005 0008
0009 0007 0009 0003 0002 0003
0004 fff3 fff7 000f

// ==== project.f ====
+incdir+verilog
verilog/renkon_pkg.sv
verilog/conv_ctrl.sv
verilog/pixel_counter.sv
verilog/line_window.sv
verilog/conv_tree9.sv
verilog/renkon_conv.sv
verif/renkon_conv_assertions.sv
verif/renkon_conv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module renkon_conv_tb -o renkon_conv_sim

# a simulator that stops on its own counts as a failed run
./obj_dir/renkon_conv_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
